// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/cpu_top.sv
dv/cpu_tb.sv

// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_1000

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        alu_logic = 3'b001,
        alu_shift = 3'b010,
        alu_arith = 3'b100,
        alu_jump  = 3'b110,
        alu_mem   = 3'b111
    } alu_sel_e;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t aop_or   = 3'd0;
    localparam alu_op_t aop_and  = 3'd1;
    localparam alu_op_t aop_xor  = 3'd2;
    localparam alu_op_t aop_sll  = 3'd0;
    localparam alu_op_t aop_srl  = 3'd1;
    localparam alu_op_t aop_sra  = 3'd2;
    localparam alu_op_t aop_add  = 3'd0;
    localparam alu_op_t aop_sub  = 3'd1;
    localparam alu_op_t aop_slt  = 3'd2;
    localparam alu_op_t aop_sltu = 3'd3;

    // Widths for the mem group, loads below mem_sb
    localparam alu_op_t mem_lb  = 3'd0;
    localparam alu_op_t mem_lh  = 3'd1;
    localparam alu_op_t mem_lw  = 3'd2;
    localparam alu_op_t mem_lbu = 3'd3;
    localparam alu_op_t mem_lhu = 3'd4;
    localparam alu_op_t mem_sb  = 3'd5;
    localparam alu_op_t mem_sh  = 3'd6;
    localparam alu_op_t mem_sw  = 3'd7;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r_view;
        u_view_t u_view;
    } inst_u;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic          valid;
        logic [31:0]   pc;
        isa_pkg::inst_u inst;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::alu_sel_e alusel;
        isa_pkg::alu_op_t  aluop;
        logic [31:0]       op1;
        logic [31:0]       op2;
        logic [31:0]       store_data;   // Already forwarded
        logic [31:0]       mem_offset;
        logic [31:0]       link_addr;
        logic              write;
        logic [4:0]        rd;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      result;        // ALU result or memory address
        logic [31:0]      store_data;
        logic             is_mem;
        isa_pkg::alu_op_t mem_op;
        logic             write;
        logic [4:0]       rd;
    } ex_mem_t;

    typedef struct packed {
        logic        write;
        logic [4:0]  rd;
        logic [31:0] data;
    } mem_wb_t;

    typedef struct packed {
        logic        write;
        logic        load;
        logic [4:0]  rd;
        logic [31:0] data;
    } fwd_t;

endpackage

// File: decode/decode_stage.sv
module decode_stage (
    input  logic             clk,
    input  logic             reset,
    input  pipe_pkg::if_id_t if_id,
    input  logic [31:0]      reg1_data,
    input  logic [31:0]      reg2_data,
    input  pipe_pkg::fwd_t   ex_fwd,
    input  pipe_pkg::fwd_t   mem_fwd,
    output logic [4:0]       reg1_addr,
    output logic [4:0]       reg2_addr,
    output logic             stall,
    output logic             br,
    output logic [31:0]      br_addr,
    output pipe_pkg::id_ex_t id_ex
);

    isa_pkg::inst_u    inst;
    logic [31:0]       iw;
    logic [31:0]       i_imm;
    logic [31:0]       s_imm;
    logic [31:0]       b_imm;
    logic [31:0]       j_imm;
    logic [31:0]       u_imm;
    logic [31:0]       imm1;
    logic [31:0]       imm2;
    logic [31:0]       mem_offset;
    logic [31:0]       src1;
    logic [31:0]       src2;
    isa_pkg::alu_sel_e alusel;
    isa_pkg::alu_op_t  aluop;
    logic              use1;
    logic              use2;
    logic              write;
    logic              is_jal;
    logic              is_jalr;
    logic              is_branch;
    logic              taken;

    // Execute stage first, then memory stage, then register file
    function automatic logic [31:0] pick(input logic [4:0] addr, input logic [31:0] rf_data,
                                         input pipe_pkg::fwd_t ex_f, input pipe_pkg::fwd_t mem_f);
        if (addr == 5'd0)
            return '0;
        if (ex_f.write && ex_f.rd == addr)
            return ex_f.data;
        if (mem_f.write && mem_f.rd == addr)
            return mem_f.data;
        return rf_data;
    endfunction

    assign inst  = if_id.inst;
    assign iw    = inst;
    assign i_imm = {{20{iw[31]}}, iw[31:20]};
    assign s_imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    assign b_imm = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
    assign j_imm = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    assign u_imm = {inst.u_view.imm, 12'b0};

    always_comb begin
        alusel = isa_pkg::alu_arith;  // Unsupported opcodes become a no-op add
        aluop = isa_pkg::aop_add;
        use1 = 1'b0;
        use2 = 1'b0;
        imm1 = '0;
        imm2 = '0;
        mem_offset = '0;
        write = 1'b0;
        is_jal = 1'b0;
        is_jalr = 1'b0;
        is_branch = 1'b0;
        case (inst.r_view.opcode)
            isa_pkg::op_lui: begin
                imm1 = u_imm;
                write = 1'b1;
            end
            isa_pkg::op_auipc: begin
                imm1 = u_imm;
                imm2 = if_id.pc;
                write = 1'b1;
            end
            isa_pkg::op_jal: begin
                alusel = isa_pkg::alu_jump;
                is_jal = 1'b1;
                write = 1'b1;
            end
            isa_pkg::op_jalr: begin
                alusel = isa_pkg::alu_jump;
                use1 = 1'b1;
                is_jalr = 1'b1;
                write = 1'b1;
            end
            isa_pkg::op_branch: begin
                alusel = isa_pkg::alu_jump;
                use1 = 1'b1;
                use2 = 1'b1;
                is_branch = 1'b1;
            end
            isa_pkg::op_load: begin
                alusel = isa_pkg::alu_mem;
                use1 = 1'b1;
                mem_offset = i_imm;
                write = 1'b1;
                case (inst.r_view.funct3)
                    3'b000: aluop = isa_pkg::mem_lb;
                    3'b001: aluop = isa_pkg::mem_lh;
                    3'b100: aluop = isa_pkg::mem_lbu;
                    3'b101: aluop = isa_pkg::mem_lhu;
                    default: aluop = isa_pkg::mem_lw;
                endcase
            end
            isa_pkg::op_store: begin
                alusel = isa_pkg::alu_mem;
                use1 = 1'b1;
                use2 = 1'b1;
                mem_offset = s_imm;
                case (inst.r_view.funct3)
                    3'b000: aluop = isa_pkg::mem_sb;
                    3'b001: aluop = isa_pkg::mem_sh;
                    default: aluop = isa_pkg::mem_sw;
                endcase
            end
            isa_pkg::op_imm: begin
                use1 = 1'b1;
                imm2 = i_imm;                    // Shifts use the low 5 bits only
                write = 1'b1;
            end
            isa_pkg::op_reg: begin
                use1 = 1'b1;
                use2 = 1'b1;
                write = 1'b1;
            end
            default: ;
        endcase
        if (inst.r_view.opcode == isa_pkg::op_imm || inst.r_view.opcode == isa_pkg::op_reg) begin
            case (inst.r_view.funct3)
                3'b000: aluop = (use2 && inst.r_view.funct7[5]) ? isa_pkg::aop_sub : isa_pkg::aop_add;
                3'b001: begin
                    alusel = isa_pkg::alu_shift;
                    aluop = isa_pkg::aop_sll;
                end
                3'b010: aluop = isa_pkg::aop_slt;
                3'b011: aluop = isa_pkg::aop_sltu;
                3'b100: begin
                    alusel = isa_pkg::alu_logic;
                    aluop = isa_pkg::aop_xor;
                end
                3'b101: begin
                    alusel = isa_pkg::alu_shift;
                    aluop = inst.r_view.funct7[5] ? isa_pkg::aop_sra : isa_pkg::aop_srl;
                end
                3'b110: begin
                    alusel = isa_pkg::alu_logic;
                    aluop = isa_pkg::aop_or;
                end
                default: begin
                    alusel = isa_pkg::alu_logic;
                    aluop = isa_pkg::aop_and;
                end
            endcase
        end
    end

    assign reg1_addr = use1 ? inst.r_view.rs1 : 5'd0;
    assign reg2_addr = use2 ? inst.r_view.rs2 : 5'd0;
    assign src1 = pick(reg1_addr, reg1_data, ex_fwd, mem_fwd);
    assign src2 = pick(reg2_addr, reg2_data, ex_fwd, mem_fwd);

    // Load in execute has no data yet
    assign stall = if_id.valid && ex_fwd.load &&
                   ((reg1_addr != 5'd0 && ex_fwd.rd == reg1_addr) ||
                    (reg2_addr != 5'd0 && ex_fwd.rd == reg2_addr));

    always_comb begin
        case (inst.r_view.funct3)
            3'b000: taken = src1 == src2;
            3'b001: taken = src1 != src2;
            3'b100: taken = $signed(src1) < $signed(src2);
            3'b101: taken = $signed(src1) >= $signed(src2);
            3'b110: taken = src1 < src2;
            3'b111: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    assign br = if_id.valid && !stall && (is_jal || is_jalr || (is_branch && taken));
    assign br_addr = is_jalr ? ((src1 + i_imm) & ~32'd1) :
                     is_jal ? (if_id.pc + j_imm) : (if_id.pc + b_imm);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
            id_ex.write <= 1'b0;
        end else begin
            id_ex.valid <= if_id.valid && !stall;  // Bubble on load-use
            id_ex.write <= if_id.valid && !stall && write && inst.r_view.rd != 5'd0;
        end
        id_ex.alusel <= alusel;
        id_ex.aluop <= aluop;
        id_ex.op1 <= use1 ? src1 : imm1;
        id_ex.op2 <= use2 ? src2 : imm2;
        id_ex.store_data <= src2;
        id_ex.mem_offset <= mem_offset;
        id_ex.link_addr <= if_id.pc + 32'd4;
        id_ex.rd <= inst.r_view.rd;
    end

    assert property (@(posedge clk) disable iff (reset) stall |=> !stall);
    assert property (@(posedge clk) disable iff (reset) id_ex.valid |->
        !$isunknown(id_ex.alusel) && id_ex.alusel inside {isa_pkg::alu_logic,
        isa_pkg::alu_shift, isa_pkg::alu_arith, isa_pkg::alu_jump, isa_pkg::alu_mem});

endmodule

// File: decode/reg_file.sv
module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic [4:0]        reg1_addr,
    input  logic [4:0]        reg2_addr,
    input  pipe_pkg::mem_wb_t wb,
    output logic [31:0]       reg1_data,
    output logic [31:0]       reg2_data
);

    logic [31:0] regs [1:31];

    // x0 is zero, same-cycle write passes straight through
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (wb.write && wb.rd == addr)
            return wb.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        reg1_data = read_port(reg1_addr);
        reg2_data = read_port(reg2_addr);
    end

    assert property (@(posedge clk) disable iff (reset) wb.write |-> wb.rd != 5'd0);

endmodule

// File: dv/cpu_tb.sv
`include "cpu_defs.svh"

module cpu_tb;

    localparam int          IMEM_AW = 10;
    localparam int          IMEM_WORDS = 2 ** IMEM_AW;
    localparam logic [31:0] JAL_SELF = 32'h0000_006f;  // jal x0, 0
    localparam int          QUIET_CYCLES = 10;
    localparam string       CASES_FILE = "dv/program_cases.txt";

    logic           clk = 1'b0;
    logic           reset;
    isa_pkg::inst_u imem_data;
    logic [31:0]    imem_addr;
    logic           wb_write;
    logic [4:0]     wb_addr;
    logic [31:0]    wb_data;

    logic [31:0] imem [IMEM_WORDS];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];
    int          num_words;
    int          seen;
    int          quiet;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;

    cpu_top dut_i (
        .clk(clk),
        .reset(reset),
        .imem_data(imem_data),
        .imem_addr(imem_addr),
        .wb_write(wb_write),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    // Unfilled words hold a jump to itself
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < IMEM_WORDS)
            return imem[idx[IMEM_AW-1:0]];
        return JAL_SELF;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[IMEM_AW-1:0]] = JAL_SELF;
        end
        num_words = 0;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", CASES_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h", kind, a, b);
                if (n >= 2 && kind == "P" && num_words < IMEM_WORDS) begin
                    imem[num_words[IMEM_AW-1:0]] = a;
                    num_words++;
                end else if (n >= 3 && kind == "W") begin
                    exp_reg.push_back(a[4:0]);
                    exp_val.push_back(b);
                end
            end
        end
        $fclose(fd);
        if (exp_val.size() == 0) begin
            $display("The cases file holds no expected writebacks");
            errors++;
        end
    endtask

    task automatic check_writeback();
        if (seen >= exp_val.size()) begin
            $display("Unexpected writeback of %h to x%0d after all expected writebacks",
                     wb_data, wb_addr);
            errors++;
        end else begin
            checks += 2;
            if (wb_addr !== exp_reg[seen]) begin
                $display("FAILED wb_addr: got %h, expected %h at writeback %0d",
                         wb_addr, exp_reg[seen], seen);
                errors++;
            end
            if (wb_data !== exp_val[seen]) begin
                $display("FAILED wb_data: got %h, expected %h at writeback %0d",
                         wb_data, exp_val[seen], seen);
                errors++;
            end
            seen++;
        end
    endtask

    // Mid-cycle: serve the fetch and look at the writeback port
    always @(negedge clk) begin
        imem_data <= fetch_word(imem_addr);
        if (reset) begin
            checks += 2;
            if (wb_write !== 1'b0) begin
                $display("FAILED wb_write: got %h, expected %h during reset", wb_write, 1'b0);
                errors++;
            end
            if (imem_addr !== `RESET_PC) begin
                $display("FAILED imem_addr: got %h, expected %h during reset",
                         imem_addr, `RESET_PC);
                errors++;
            end
        end else if (wb_write) begin
            quiet = 0;
            check_writeback();
        end else begin
            quiet++;
        end
    end

    initial begin
        reset = 1'b1;
        imem_data = '0;
        seen = 0;
        quiet = 0;
        errors = 0;
        checks = 0;
        cycles = 0;
        load_cases();
        limit = 20 + 4 * num_words;
        repeat (5) @(negedge clk);
        reset <= 1'b0;
        while ((seen < exp_val.size() || quiet < QUIET_CYCLES) && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (seen < exp_val.size() || quiet < QUIET_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycles, seen, exp_val.size());
            errors++;
        end
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: dv/program_cases.txt
# P word: instruction word, placed in order from the reset PC
# W reg value: expected writeback in program order, all numbers in hex
P 00500093 # addi x1, x0, 5
W 01 00000005
P ffd00113 # addi x2, x0, -3
W 02 fffffffd
P 002081b3 # add x3, x1, x2
W 03 00000002
P 40208233 # sub x4, x1, x2
W 04 00000008
P 001122b3 # slt x5, x2, x1
W 05 00000001
P 00113333 # sltu x6, x2, x1
W 06 00000000
P 0f014393 # xori x7, x2, 0xf0
W 07 ffffff0d
P 1000e413 # ori x8, x1, 0x100
W 08 00000105
P 07f17493 # andi x9, x2, 0x7f
W 09 0000007d
P 0020c533 # xor x10, x1, x2
W 0a fffffff8
P 0020e5b3 # or x11, x1, x2
W 0b fffffffd
P 0020f633 # and x12, x1, x2
W 0c 00000005
P 123456b7 # lui x13, 0x12345
W 0d 12345000
P 00001717 # auipc x14, 0x1 at 0x1034
W 0e 00002034
P f0000793 # addi x15, x0, -256
W 0f ffffff00
P 00400813 # addi x16, x0, 4
W 10 00000004
P 010798b3 # sll x17, x15, x16
W 11 fffff000
P 0107d933 # srl x18, x15, x16
W 12 0ffffff0
P 4107d9b3 # sra x19, x15, x16
W 13 fffffff0
P 00879a13 # slli x20, x15, 8
W 14 ffff0000
P 0087da93 # srli x21, x15, 8
W 15 00ffffff
P 4087db13 # srai x22, x15, 8
W 16 ffffffff
P 10000b93 # addi x23, x0, 0x100
W 17 00000100
P 89abdc37 # lui x24, 0x89abd
W 18 89abd000
P defc0c13 # addi x24, x24, -0x211
W 18 89abcdef
P 018ba023 # sw x24, 0(x23)
P 000bac83 # lw x25, 0(x23)
W 19 89abcdef
P 001c8d13 # addi x26, x25, 1 with load-use stall
W 1a 89abcdf0
P 000b8d83 # lb x27, 0(x23)
W 1b ffffffef
P 001bce03 # lbu x28, 1(x23)
W 1c 000000cd
P 002b9e83 # lh x29, 2(x23)
W 1d ffff89ab
P 000bdf03 # lhu x30, 0(x23)
W 1e 0000cdef
P 000ba223 # sw x0, 4(x23)
P 001b82a3 # sb x1, 5(x23)
P 002b9323 # sh x2, 6(x23)
P 004baf83 # lw x31, 4(x23)
W 1f fffd0500
P 00208463 # beq x1, x2 not taken
P 01100193 # addi x3, x0, 0x11
W 03 00000011
P 00108463 # beq x1, x1 taken
P 7ff00193 # squashed
P 00109463 # bne x1, x1 not taken
P 02200213 # addi x4, x0, 0x22
W 04 00000022
P 00209463 # bne x1, x2 taken
P 7ff00213 # squashed
P 0020c463 # blt x1, x2 not taken
P 03300293 # addi x5, x0, 0x33
W 05 00000033
P 00114463 # blt x2, x1 taken
P 7ff00293 # squashed
P 00115463 # bge x2, x1 not taken
P 04400313 # addi x6, x0, 0x44
W 06 00000044
P 0020d463 # bge x1, x2 taken
P 7ff00313 # squashed
P 00116463 # bltu x2, x1 not taken
P 05500393 # addi x7, x0, 0x55
W 07 00000055
P 0020e463 # bltu x1, x2 taken
P 7ff00393 # squashed
P 0020f463 # bgeu x1, x2 not taken
P 06600413 # addi x8, x0, 0x66
W 08 00000066
P 00117463 # bgeu x2, x1 taken
P 7ff00413 # squashed
P 000ba483 # lw x9, 0(x23)
W 09 89abcdef
P 01848463 # beq x9, x24 taken after a stall
P 7ff00493 # squashed
P 0080056f # jal x10, +8 at 0x10fc
W 0a 00001100
P 7ff00513 # squashed
P 00000597 # auipc x11, 0 at 0x1104
W 0b 00001104
P 00c58667 # jalr x12, 12(x11)
W 0c 0000110c
P 7ff00613 # squashed
P 00708013 # addi x0, x1, 7 writes nothing
P 000006b3 # add x13, x0, x0
W 0d 00000000

// File: rtl/cpu_top.sv
module cpu_top (
    input  logic           clk,
    input  logic           reset,
    input  isa_pkg::inst_u imem_data,
    output logic [31:0]    imem_addr,
    output logic           wb_write,
    output logic [4:0]     wb_addr,
    output logic [31:0]    wb_data
);

    pipe_pkg::if_id_t  if_id;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    pipe_pkg::mem_wb_t mem_wb;
    pipe_pkg::fwd_t    ex_fwd;
    pipe_pkg::fwd_t    mem_fwd;
    logic              stall;
    logic              br;
    logic [31:0]       br_addr;
    logic [4:0]        reg1_addr;
    logic [4:0]        reg2_addr;
    logic [31:0]       reg1_data;
    logic [31:0]       reg2_data;

    fetch_stage fetch_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .br(br),
        .br_addr(br_addr),
        .imem_data(imem_data),
        .imem_addr(imem_addr),
        .if_id(if_id)
    );

    decode_stage decode_i (
        .clk(clk),
        .reset(reset),
        .if_id(if_id),
        .reg1_data(reg1_data),
        .reg2_data(reg2_data),
        .ex_fwd(ex_fwd),
        .mem_fwd(mem_fwd),
        .reg1_addr(reg1_addr),
        .reg2_addr(reg2_addr),
        .stall(stall),
        .br(br),
        .br_addr(br_addr),
        .id_ex(id_ex)
    );

    reg_file reg_file_i (
        .clk(clk),
        .reset(reset),
        .reg1_addr(reg1_addr),
        .reg2_addr(reg2_addr),
        .wb(mem_wb),
        .reg1_data(reg1_data),
        .reg2_data(reg2_data)
    );

    execute_stage execute_i (
        .clk(clk),
        .reset(reset),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .ex_fwd(ex_fwd)
    );

    mem_stage mem_i (
        .clk(clk),
        .reset(reset),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .mem_fwd(mem_fwd)
    );

    assign wb_write = mem_wb.write;
    assign wb_addr = mem_wb.rd;
    assign wb_data = mem_wb.data;

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::fwd_t    ex_fwd
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;
    logic [31:0] result;
    logic        is_load;

    assign op1 = id_ex.op1;
    assign op2 = id_ex.op2;
    assign shamt = op2[4:0];

    always_comb begin
        result = '0;
        case (id_ex.alusel)
            isa_pkg::alu_logic: begin
                case (id_ex.aluop)
                    isa_pkg::aop_or: result = op1 | op2;
                    isa_pkg::aop_and: result = op1 & op2;
                    default: result = op1 ^ op2;
                endcase
            end
            isa_pkg::alu_shift: begin
                case (id_ex.aluop)
                    isa_pkg::aop_sll: result = op1 << shamt;
                    isa_pkg::aop_srl: result = op1 >> shamt;
                    default: result = $signed(op1) >>> shamt;  // Keeps the sign
                endcase
            end
            isa_pkg::alu_arith: begin
                case (id_ex.aluop)
                    isa_pkg::aop_add: result = op1 + op2;
                    isa_pkg::aop_sub: result = op1 - op2;
                    isa_pkg::aop_slt: result = {31'b0, $signed(op1) < $signed(op2)};
                    default: result = {31'b0, op1 < op2};
                endcase
            end
            isa_pkg::alu_jump: result = id_ex.link_addr;
            isa_pkg::alu_mem: result = op1 + id_ex.mem_offset;  // Effective address
            default: result = '0;
        endcase
    end

    assign is_load = id_ex.alusel == isa_pkg::alu_mem && id_ex.aluop < isa_pkg::mem_sb;

    assign ex_fwd = '{write: id_ex.valid && id_ex.write,
                      load: id_ex.valid && id_ex.write && is_load,
                      rd: id_ex.rd,
                      data: result};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
            ex_mem.write <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.write <= id_ex.valid && id_ex.write;
        end
        ex_mem.result <= result;
        ex_mem.store_data <= id_ex.store_data;
        ex_mem.is_mem <= id_ex.alusel == isa_pkg::alu_mem;
        ex_mem.mem_op <= id_ex.aluop;
        ex_mem.rd <= id_ex.rd;
    end

endmodule

// File: rtl/fetch_stage.sv
`include "cpu_defs.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             br,
    input  logic [31:0]      br_addr,
    input  isa_pkg::inst_u   imem_data,
    output logic [31:0]      imem_addr,
    output pipe_pkg::if_id_t if_id
);

    logic [31:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!stall) begin    // Stall wins over redirect
            if (br) begin
                pc <= br_addr;
                if_id.valid <= 1'b0;  // Squash the fetched slot
            end else begin
                pc <= pc + 32'd4;
                if_id.valid <= 1'b1;
            end
        end
        if (!stall) begin
            if_id.pc <= pc;
            if_id.inst <= imem_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) br |-> br_addr[1:0] == 2'b00);

endmodule

// File: rtl/mem_stage.sv
`include "cpu_defs.svh"

module mem_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_wb,
    output pipe_pkg::fwd_t    mem_fwd
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [31:0]   dmem [`DMEM_WORDS];
    logic [AW-1:0] word_idx;
    logic [1:0]    lane;
    logic [31:0]   shifted;
    logic [31:0]   load_data;
    logic [31:0]   wb_data;
    logic          is_load;
    logic          is_store;
    logic          is_half;
    logic          is_word;

    assign word_idx = ex_mem.result[AW+1:2];
    assign lane = ex_mem.result[1:0];
    assign is_load = ex_mem.valid && ex_mem.is_mem && ex_mem.mem_op < isa_pkg::mem_sb;
    assign is_store = ex_mem.valid && ex_mem.is_mem && ex_mem.mem_op >= isa_pkg::mem_sb;
    assign is_half = ex_mem.mem_op inside {isa_pkg::mem_lh, isa_pkg::mem_lhu, isa_pkg::mem_sh};
    assign is_word = ex_mem.mem_op inside {isa_pkg::mem_lw, isa_pkg::mem_sw};
    assign shifted = dmem[word_idx] >> {lane, 3'b000};  // Addressed byte to bit 0

    always_comb begin
        case (ex_mem.mem_op)
            isa_pkg::mem_lb: load_data = {{24{shifted[7]}}, shifted[7:0]};
            isa_pkg::mem_lbu: load_data = {24'b0, shifted[7:0]};
            isa_pkg::mem_lh: load_data = {{16{shifted[15]}}, shifted[15:0]};
            isa_pkg::mem_lhu: load_data = {16'b0, shifted[15:0]};
            default: load_data = dmem[word_idx];
        endcase
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            case (ex_mem.mem_op)
                isa_pkg::mem_sb: dmem[word_idx][{lane, 3'b000} +: 8] <= ex_mem.store_data[7:0];
                isa_pkg::mem_sh: dmem[word_idx][{lane[1], 4'b0000} +: 16] <= ex_mem.store_data[15:0];
                default: dmem[word_idx] <= ex_mem.store_data;
            endcase
        end
    end

    assign wb_data = is_load ? load_data : ex_mem.result;
    assign mem_fwd = '{write: ex_mem.write, load: is_load, rd: ex_mem.rd, data: wb_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.write <= 1'b0;
        end else begin
            mem_wb.write <= ex_mem.write;
        end
        mem_wb.rd <= ex_mem.rd;
        mem_wb.data <= wb_data;
    end

    assert property (@(posedge clk) disable iff (reset) ex_mem.valid && ex_mem.is_mem |->
        !(is_half && lane[0]) && !(is_word && lane != 2'b00));

endmodule
